/* compile.f */
logic/sudoku_pkg.sv
logic/sudoku_apb_regs.sv
logic/button_decoder.sv
logic/board_updater.sv
logic/game_result.sv
logic/sudoku_top.sv
test/sudoku_sva.sv
test/sudoku_tb.sv

/* test/sudoku_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sudoku_tb;
    import sudoku_pkg::*;

    // the longest run is about 700 cycles of APB traffic plus some 40 presses
    localparam int max_cycles = 20000;
    localparam int btn_up     = 0;
    localparam int btn_down   = 1;
    localparam int btn_a      = 2;
    localparam int btn_b      = 3;

    logic                     clk;
    logic                     reset;
    logic [apb_addr_bits-1:0] paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apb_data_bits-1:0] pwdata;
    logic [apb_data_bits-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     up_button;
    logic                     down_button;
    logic                     a_button;
    logic                     b_button;
    game_state_t              state;
    logic [strike_bits-1:0]   strikes;
    logic                     error;
    logic [cell_bits-1:0]     selected_number;

    int                   cycle_count;
    int                   fail_count;
    logic [cell_bits-1:0] digits [num_cells];  // staged puzzle
    logic [cell_bits-1:0] exp_sel;             // model of the selected number

    sudoku_top u_sudoku_top (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .up_button(up_button), .down_button(down_button),
        .a_button(a_button), .b_button(b_button),
        .state(state), .strikes(strikes), .error(error), .selected_number(selected_number)
    );

    bind sudoku_top sudoku_sva u_sva (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
        .state(state), .strikes(strikes), .selected_number(selected_number)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", max_cycles);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped by the cycle limit");
    end

    // ******************************************************************
    // compare tasks
    // ******************************************************************
    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        fail_count++;
        $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_state(input game_state_t got, input game_state_t want,
                               input string what);
        if (got !== want) report_mismatch(what, 32'(got), 32'(want));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        if (got !== want) report_mismatch(what, got, want);
    endtask

    task automatic check_nibble(input logic [3:0] got, input logic [3:0] want,
                                input string what);
        if (got !== want) report_mismatch(what, 32'(got), 32'(want));
    endtask

    task automatic check_strikes(input logic [1:0] got, input logic [1:0] want,
                                 input string what);
        if (got !== want) report_mismatch(what, 32'(got), 32'(want));
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) report_mismatch(what, 32'(got), 32'(want));
    endtask

    // ******************************************************************
    // drivers
    // ******************************************************************
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);  // middle of the access phase
        rdata = prdata;
        err   = pslverr;
        check_flag(pready, 1'b1, "pready in the access phase");
        @(posedge clk);  // a write commits on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_flag(err, exp_err, $sformatf("pslverr on write to 0x%03h", addr));
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check_flag(err, 1'b0, $sformatf("pslverr on read of 0x%03h", addr));
    endtask

    task automatic drive_button(input int button, input logic level);
        case (button)
            btn_up:   up_button   <= level;
            btn_down: down_button <= level;
            btn_a:    a_button    <= level;
            default:  b_button    <= level;
        endcase
    endtask

    // outputs follow at the second edge after the rise, sampled at the next negedge
    task automatic press(input int button, input int hold_cycles);
        @(posedge clk);
        drive_button(button, 1'b1);
        repeat (hold_cycles) @(posedge clk);
        drive_button(button, 1'b0);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_for_state(input game_state_t want);
        @(negedge clk);
        while (state !== want) begin
            @(negedge clk);
        end
    endtask

    function automatic logic [31:0] status_word(input game_state_t st, input logic [1:0] stk,
                                                input logic err, input logic [3:0] sel,
                                                input int count);
        logic [31:0] w;
        w        = '0;
        w[2:0]   = st;
        w[4:3]   = stk;
        w[5]     = err;
        w[11:8]  = sel;
        w[22:16] = count[6:0];
        return w;
    endfunction

    task automatic check_status(input game_state_t st, input logic [1:0] stk, input logic err,
                                input logic [3:0] sel, input int count);
        logic [31:0] rd;
        apb_read(addr_status, rd);
        check_word(rd, status_word(st, stk, err, sel, count), "status word");
    endtask

    task automatic select_number(input logic [3:0] target);
        while (exp_sel != target) begin
            press(btn_up, 1);
            exp_sel = (exp_sel % 4'd9) + 4'd1;
            check_nibble(selected_number, exp_sel, "selected number");
        end
    endtask

    task automatic start_game();
        apb_write(addr_ctrl, 32'h1, 1'b0);
        wait_for_state(st_playing);
        exp_sel = 4'd1;
    endtask

    // ******************************************************************
    // directed tests
    // ******************************************************************
    task automatic test_registers();
        logic [31:0] rd;
        check_state(state, st_idle, "state after reset");
        check_strikes(strikes, 2'd0, "strikes after reset");
        check_nibble(selected_number, 4'd1, "selected number after reset");
        apb_write(addr_cursor, 32'd5, 1'b0);
        apb_read(addr_cursor, rd);
        check_word(rd, 32'd5, "cursor readback");
        apb_write(12'h300, 32'h1, 1'b1);  // unmapped
        apb_write(addr_status, 32'h0, 1'b1);
        apb_write(addr_cursor, 32'd81, 1'b1);
        apb_read(addr_cursor, rd);
        check_word(rd, 32'd5, "cursor after rejected writes");
    endtask

    task automatic test_start_and_load();
        logic [31:0] rd;
        logic [31:0] want;
        for (int i = 0; i < num_cells; i++) begin
            digits[i] = 4'(($urandom % 9) + 1);
            want      = 32'(digits[i]) | ((i != 0) ? 32'h10 : 32'h0);  // only cell 0 hidden
            apb_write(addr_cell_base + 12'(4 * i), want, 1'b0);
        end
        apb_write(addr_cursor, 32'd0, 1'b0);
        start_game();
        check_state(state, st_playing, "state after start");
        check_strikes(strikes, 2'd0, "strikes after start");
        check_nibble(selected_number, 4'd1, "selected number after start");
        check_status(st_playing, 2'd0, 1'b0, 4'd1, 80);
        for (int i = 0; i < num_cells; i++) begin
            want = 32'(digits[i]) | ((i != 0) ? 32'h10 : 32'h0);
            apb_read(addr_cell_base + 12'(4 * i), rd);
            check_word(rd, want, $sformatf("cell %0d readback", i));
        end
    endtask

    task automatic test_number_select();
        press(btn_down, 1);
        exp_sel = 4'd9;
        check_nibble(selected_number, exp_sel, "down from 1");
        for (int k = 0; k < 9; k++) begin
            press(btn_up, 1);
            exp_sel = (exp_sel % 4'd9) + 4'd1;
            check_nibble(selected_number, exp_sel, "up step");
        end
        press(btn_up, 6);  // held level gives one step
        exp_sel = 4'd1;
        repeat (3) @(negedge clk);
        check_nibble(selected_number, exp_sel, "held up button");
    endtask

    task automatic test_wrong_guesses();
        logic [3:0] wrong;
        wrong = (digits[0] == 4'd9) ? 4'd1 : digits[0] + 4'd1;
        select_number(wrong);
        press(btn_a, 1);
        check_flag(error, 1'b1, "error after wrong guess");
        check_strikes(strikes, 2'd1, "strikes after first wrong guess");
        press(btn_b, 1);
        check_flag(error, 1'b0, "error after b");
        check_strikes(strikes, 2'd1, "strikes after b");
        press(btn_a, 1);
        check_strikes(strikes, 2'd2, "strikes after second wrong guess");
        press(btn_a, 1);
        check_strikes(strikes, 2'd3, "strikes after third wrong guess");
        wait_for_state(st_lost);
        press(btn_up, 1);  // ignored once lost
        press(btn_a, 1);
        check_state(state, st_lost, "state after presses when lost");
        check_nibble(selected_number, wrong, "selected number when lost");
        check_strikes(strikes, 2'd3, "strikes when lost");
        check_flag(error, 1'b1, "error when lost");
        check_status(st_lost, 2'd3, 1'b1, wrong, 80);
    endtask

    task automatic test_win();
        logic [31:0] rd;
        start_game();
        check_strikes(strikes, 2'd0, "strikes after restart");
        check_flag(error, 1'b0, "error after restart");
        check_nibble(selected_number, 4'd1, "selected number after restart");
        select_number(digits[0]);
        press(btn_a, 1);
        wait_for_state(st_won);
        check_flag(error, 1'b0, "error after win");
        apb_read(addr_cell_base, rd);
        check_word(rd, 32'h10 | 32'(digits[0]), "cell 0 after correct guess");
        check_status(st_won, 2'd0, 1'b0, digits[0], 81);
    endtask

    initial begin
        int seed_value;
        seed_value  = $urandom(16);
        reset       = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        up_button   = 1'b0;
        down_button = 1'b0;
        a_button    = 1'b0;
        b_button    = 1'b0;
        fail_count  = 0;
        exp_sel     = 4'd1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        test_registers();
        test_start_and_load();
        test_number_select();
        test_wrong_guesses();
        test_win();

        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/sudoku_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module sudoku_sva (
    input wire                                clk,
    input wire                                reset,
    input wire                                psel,
    input wire                                penable,
    input wire                                pready,
    input wire sudoku_pkg::game_state_t       state,
    input wire [sudoku_pkg::strike_bits-1:0]  strikes,
    input wire [sudoku_pkg::cell_bits-1:0]    selected_number
);
    import sudoku_pkg::*;

    // ******************************************************************
    // APB protocol
    // ******************************************************************
    penable_needs_psel: assert property (@(posedge clk) disable iff (reset) penable |-> psel)
        else $error("penable is high while psel is low");

    pready_tied_high: assert property (@(posedge clk) disable iff (reset) pready)
        else $error("pready dropped low");

    // ******************************************************************
    // game outputs
    // ******************************************************************
    // only a new load takes the count back down from the limit
    strikes_saturate: assert property (@(posedge clk) disable iff (reset)
        ((strikes == max_strikes) && (state != st_loading)) |=> (strikes == max_strikes))
        else $error("strike count wrapped past the limit");

    number_in_range: assert property (@(posedge clk) disable iff (reset)
        (selected_number >= 4'd1) && (selected_number <= 4'd9))
        else $error("selected number left the range 1 to 9");

    loading_lasts_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (state == st_loading) |=> (state != st_loading))
        else $error("state stayed in loading for more than one cycle");

endmodule

`default_nettype wire

/* logic/sudoku_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sudoku_top (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire [sudoku_pkg::apb_addr_bits-1:0]  paddr,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire [sudoku_pkg::apb_data_bits-1:0]  pwdata,
    output logic [sudoku_pkg::apb_data_bits-1:0] prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  wire                                  up_button,
    input  wire                                  down_button,
    input  wire                                  a_button,
    input  wire                                  b_button,
    output sudoku_pkg::game_state_t              state,
    output logic [sudoku_pkg::strike_bits-1:0]   strikes,
    output logic                                 error,
    output logic [sudoku_pkg::cell_bits-1:0]     selected_number
);
    import sudoku_pkg::*;

    logic [board_bits-1:0] staged_map;
    logic [num_cells-1:0]  staged_visibility;
    logic [index_bits-1:0] cursor;
    logic                  start_pulse;
    logic                  up_pulse;
    logic                  down_pulse;
    logic                  a_pulse;
    logic                  b_pulse;
    logic [board_bits-1:0] board;
    logic [num_cells-1:0]  visibilities;

    sudoku_apb_regs u_apb_regs (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .board(board), .visibilities(visibilities), .state(state), .strikes(strikes),
        .error(error), .selected_number(selected_number),
        .staged_map(staged_map), .staged_visibility(staged_visibility),
        .cursor(cursor), .start_pulse(start_pulse)
    );

    // decode stage
    button_decoder u_button_decoder (
        .clk(clk), .reset(reset),
        .up_button(up_button), .down_button(down_button),
        .a_button(a_button), .b_button(b_button),
        .up_pulse(up_pulse), .down_pulse(down_pulse), .a_pulse(a_pulse), .b_pulse(b_pulse)
    );

    board_updater u_board_updater (  // execute stage
        .clk(clk), .reset(reset), .state(state),
        .up_pulse(up_pulse), .down_pulse(down_pulse), .a_pulse(a_pulse), .b_pulse(b_pulse),
        .cursor(cursor), .staged_map(staged_map), .staged_visibility(staged_visibility),
        .board(board), .visibilities(visibilities), .error(error), .strikes(strikes),
        .selected_number(selected_number)
    );

    game_result u_game_result (
        .clk(clk), .reset(reset), .start_pulse(start_pulse),
        .visibilities(visibilities), .strikes(strikes), .state(state)
    );

endmodule

`default_nettype wire

/* logic/game_result.sv */
`timescale 1ns/1ns
`default_nettype none

module game_result (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                start_pulse,
    input  wire [sudoku_pkg::num_cells-1:0]    visibilities,
    input  wire [sudoku_pkg::strike_bits-1:0]  strikes,
    output sudoku_pkg::game_state_t            state
);
    import sudoku_pkg::*;

    game_state_t next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (start_pulse) begin
            next_state = st_loading;  // restart from anywhere
        end else begin
            case (state)
                st_loading: begin
                    next_state = st_playing;
                end
                st_playing: begin
                    // a loss wins over a full board in the same cycle
                    if (strikes == max_strikes) begin
                        next_state = st_lost;
                    end else if (&visibilities) begin
                        next_state = st_won;
                    end
                end
                default: begin
                    next_state = state;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/board_updater.sv */
`timescale 1ns/1ns
`default_nettype none

module board_updater (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire sudoku_pkg::game_state_t        state,
    input  wire                                 up_pulse,
    input  wire                                 down_pulse,
    input  wire                                 a_pulse,
    input  wire                                 b_pulse,
    input  wire [sudoku_pkg::index_bits-1:0]    cursor,
    input  wire [sudoku_pkg::board_bits-1:0]    staged_map,
    input  wire [sudoku_pkg::num_cells-1:0]     staged_visibility,
    output logic [sudoku_pkg::board_bits-1:0]   board,
    output logic [sudoku_pkg::num_cells-1:0]    visibilities,
    output logic                                error,
    output logic [sudoku_pkg::strike_bits-1:0]  strikes,
    output logic [sudoku_pkg::cell_bits-1:0]    selected_number
);
    import sudoku_pkg::*;

    logic [board_bits-1:0]  next_board;
    logic [num_cells-1:0]   next_visibilities;
    logic                   next_error;
    logic [strike_bits-1:0] next_strikes;
    logic [cell_bits-1:0]   next_selected_number;
    logic [cell_bits-1:0]   cell_digit;

    assign cell_digit = board[cursor*cell_bits +: cell_bits];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board           <= '0;
            visibilities    <= '0;
            error           <= 1'b0;
            strikes         <= '0;
            selected_number <= 4'd1;
        end else begin
            board           <= next_board;
            visibilities    <= next_visibilities;
            error           <= next_error;
            strikes         <= next_strikes;
            selected_number <= next_selected_number;
        end
    end

    // ******************************************************************
    // move execution
    // ******************************************************************
    always_comb begin
        next_board           = board;
        next_visibilities    = visibilities;
        next_error           = error;
        next_strikes         = strikes;
        next_selected_number = selected_number;

        case (state)
            st_loading: begin
                next_board           = staged_map;
                next_visibilities    = staged_visibility;
                next_error           = 1'b0;
                next_strikes         = '0;
                next_selected_number = 4'd1;
            end
            st_playing: begin
                if (up_pulse | down_pulse | a_pulse | b_pulse) begin
                    next_error = 1'b0;  // any button acknowledges the error
                end

                if (up_pulse) begin
                    next_selected_number = (selected_number == 4'd9) ? 4'd1 : selected_number + 4'd1;
                end else if (down_pulse) begin
                    next_selected_number = (selected_number == 4'd1) ? 4'd9 : selected_number - 4'd1;
                end

                if (a_pulse) begin
                    if (cell_digit == selected_number) begin
                        next_visibilities[cursor] = 1'b1;
                    end else begin
                        next_error = 1'b1;
                        if (strikes != max_strikes) begin
                            next_strikes = strikes + 2'd1;
                        end
                    end
                end
            end
            default: begin
                // idle, won and lost leave the board frozen
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/button_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module button_decoder (
    input  wire  clk,
    input  wire  reset,
    input  wire  up_button,
    input  wire  down_button,
    input  wire  a_button,
    input  wire  b_button,
    output logic up_pulse,
    output logic down_pulse,
    output logic a_pulse,
    output logic b_pulse
);

    logic [3:0] level;
    logic [3:0] level_q;  // level seen at the previous edge
    logic [3:0] pulse_q;

    assign level = {up_button, down_button, a_button, b_button};

    // the pulse is registered, so it appears one cycle after the rise
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level_q <= '0;
            pulse_q <= '0;
        end else begin
            level_q <= level;
            pulse_q <= level & ~level_q;
        end
    end

    assign up_pulse   = pulse_q[3];
    assign down_pulse = pulse_q[2];
    assign a_pulse    = pulse_q[1];
    assign b_pulse    = pulse_q[0];

endmodule

`default_nettype wire

/* logic/sudoku_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module sudoku_apb_regs (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire [sudoku_pkg::apb_addr_bits-1:0] paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire [sudoku_pkg::apb_data_bits-1:0] pwdata,
    output logic [sudoku_pkg::apb_data_bits-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  wire [sudoku_pkg::board_bits-1:0]    board,
    input  wire [sudoku_pkg::num_cells-1:0]     visibilities,
    input  wire sudoku_pkg::game_state_t        state,
    input  wire [sudoku_pkg::strike_bits-1:0]   strikes,
    input  wire                                 error,
    input  wire [sudoku_pkg::cell_bits-1:0]     selected_number,
    output logic [sudoku_pkg::board_bits-1:0]   staged_map,
    output logic [sudoku_pkg::num_cells-1:0]    staged_visibility,
    output logic [sudoku_pkg::index_bits-1:0]   cursor,
    output logic                                start_pulse
);
    import sudoku_pkg::*;

    logic                  access;
    logic                  sel_cell;
    logic                  sel_ctrl;
    logic                  sel_cursor;
    logic                  sel_status;
    logic                  bad_access;
    logic                  write_ok;
    logic [index_bits-1:0] cell_idx;
    logic [index_bits-1:0] visible_count;

    function automatic logic [index_bits-1:0] count_visible(input logic [num_cells-1:0] v);
        logic [index_bits-1:0] n;
        n = '0;
        for (int i = 0; i < num_cells; i++) begin
            n = n + index_bits'(v[i]);
        end
        return n;
    endfunction

    // ******************************************************************
    // address decode and error check
    // ******************************************************************
    assign access   = psel & penable;
    assign cell_idx = paddr[index_bits+1:2];

    // cells must be word aligned and below 0x144
    assign sel_cell = (paddr[apb_addr_bits-1:index_bits+2] == '0) &&
                      (paddr[1:0] == 2'b00) && (cell_idx < num_cells);
    assign sel_ctrl   = (paddr == addr_ctrl);
    assign sel_cursor = (paddr == addr_cursor);
    assign sel_status = (paddr == addr_status);

    assign bad_access = !(sel_cell | sel_ctrl | sel_cursor | sel_status) ||
                        (pwrite && sel_status) ||
                        (pwrite && sel_cursor && (pwdata >= num_cells));

    assign pready   = 1'b1;  // no wait states
    assign pslverr  = access & bad_access;
    assign write_ok = access & pwrite & ~bad_access;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            staged_map        <= '0;
            staged_visibility <= '0;
            cursor            <= '0;
            start_pulse       <= 1'b0;
        end else begin
            start_pulse <= write_ok & sel_ctrl & pwdata[0];
            if (write_ok && sel_cell) begin
                staged_map[cell_idx*cell_bits +: cell_bits] <= pwdata[cell_bits-1:0];
                staged_visibility[cell_idx]                 <= pwdata[cell_bits];
            end
            if (write_ok && sel_cursor) begin
                cursor <= pwdata[index_bits-1:0];
            end
        end
    end

    // ******************************************************************
    // readout
    // ******************************************************************
    assign visible_count = count_visible(visibilities);

    always_comb begin
        prdata = '0;
        if (sel_cell) begin
            prdata[cell_bits-1:0] = board[cell_idx*cell_bits +: cell_bits];  // live board
            prdata[cell_bits]     = visibilities[cell_idx];
        end else if (sel_cursor) begin
            prdata[index_bits-1:0] = cursor;
        end else if (sel_status) begin
            prdata[2:0]   = state;
            prdata[4:3]   = strikes;
            prdata[5]     = error;
            prdata[11:8]  = selected_number;
            prdata[22:16] = visible_count;
        end
    end

endmodule

`default_nettype wire

/* logic/sudoku_pkg.sv */
`default_nettype none

package sudoku_pkg;

    // ******************************************************************
    // board geometry
    // ******************************************************************
    localparam int num_cells   = 81;
    localparam int cell_bits   = 4;
    localparam int board_bits  = num_cells * cell_bits;  // cell i sits at bits 4i+3:4i
    localparam int index_bits  = 7;
    localparam int strike_bits = 2;

    localparam logic [strike_bits-1:0] max_strikes = 2'd3;

    // ******************************************************************
    // APB address map
    // ******************************************************************
    localparam int apb_addr_bits = 12;
    localparam int apb_data_bits = 32;

    localparam logic [apb_addr_bits-1:0] addr_cell_base = 12'h000;  // cell i at 4i
    localparam logic [apb_addr_bits-1:0] addr_ctrl      = 12'h200;  // bit 0 requests a start
    localparam logic [apb_addr_bits-1:0] addr_cursor    = 12'h204;
    localparam logic [apb_addr_bits-1:0] addr_status    = 12'h208;  // read only

    // game state, also reported in status bits 2:0
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_loading = 3'd1,
        st_playing = 3'd2,
        st_won     = 3'd3,
        st_lost    = 3'd4
    } game_state_t;

endpackage

`default_nettype wire
